//--- logic/pipe_settings.svh
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// machine word, also the width of one instruction
`define XLEN 32

// register numbers
`define REG_W 5

// JAL links through this register
`define REG_RA 5'd31

// writes to this register are dropped by the register file
`define REG_ZERO 5'd0

`endif

//--- logic/ctrl_pkg.sv
`include "pipe_settings.svh"

package ctrl_pkg;

	// R-type and I-type views of the same instruction word
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [`REG_W-1:0] rs;
			logic [`REG_W-1:0] rt;
			logic [`REG_W-1:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0] op;
			logic [`REG_W-1:0] rs;
			logic [`REG_W-1:0] rt;
			logic [15:0] imm16;
		} i;
	} instr_t;

	typedef enum logic [5:0] {
		KIND_ADDU, KIND_SUBU, KIND_ADD, KIND_SUB, KIND_AND, KIND_OR,
		KIND_SLT, KIND_SLL, KIND_ORI, KIND_ADDI, KIND_ADDIU, KIND_LUI,
		KIND_LW, KIND_SW, KIND_BEQ, KIND_BNE, KIND_J, KIND_JAL, KIND_JR,
		KIND_MULT, KIND_DIV, KIND_MFHI, KIND_MFLO, KIND_UNKNOWN
	} op_kind_e;

	typedef enum logic [3:0] {
		CLS_NOP, CAL_R, CAL_I, LOAD, STORE, BRANCH, JUMP_I, JUMP_R, CAL_M, LOAD_M
	} op_class_e;

	typedef enum logic [2:0] {NPC_SEQ, NPC_EQ, NPC_NE, NPC_J, NPC_REG} npc_mode_e;
	typedef enum logic [1:0] {EXT_SIGN, EXT_ZERO, EXT_UPPER} ext_mode_e;
	typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_SLL} alu_op_e;
	typedef enum logic [2:0] {MD_NONE, MD_MULT, MD_DIV, MD_MFHI, MD_MFLO} md_op_e;
	typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK, WB_MD} wb_sel_e;
	typedef enum logic [1:0] {FWD_NONE, FWD_M, FWD_W} fwd_sel_e;
	typedef enum logic [2:0] {EXC_NONE, EXC_RI, EXC_OV, EXC_ADEL, EXC_ADES} exc_code_e;

	// classes whose result ends up in the register file
	function automatic logic cls_writes(input op_class_e c);
		return c inside {CAL_R, CAL_I, LOAD, JUMP_I, JUMP_R, LOAD_M};
	endfunction

endpackage

//--- logic/instr_kind.sv
`include "pipe_settings.svh"

module instr_kind import ctrl_pkg::*; (
	input instr_t instr,
	output op_kind_e kind,
	output op_class_e cls,
	output logic rs_used,
	output logic rt_used,
	output logic [`REG_W-1:0] dest
);

	logic r_type;
	logic rs_z;
	logic rt_z;
	logic rd_z;
	logic sh_z;

	assign r_type = instr.r.op == 6'b000000;
	assign rs_z = instr.r.rs == `REG_ZERO;
	assign rt_z = instr.r.rt == `REG_ZERO;
	assign rd_z = instr.r.rd == `REG_ZERO;
	assign sh_z = instr.r.shamt == 5'd0;

	// fields that must be zero are part of the match, anything else is reserved
	always_comb begin
		kind = KIND_UNKNOWN;
		if (r_type) begin
			case (instr.r.funct)
				6'b100001: if (sh_z) kind = KIND_ADDU;
				6'b100011: if (sh_z) kind = KIND_SUBU;
				6'b100000: if (sh_z) kind = KIND_ADD;
				6'b100010: if (sh_z) kind = KIND_SUB;
				6'b100100: if (sh_z) kind = KIND_AND;
				6'b100101: if (sh_z) kind = KIND_OR;
				6'b101010: if (sh_z) kind = KIND_SLT;
				6'b000000: if (rs_z) kind = KIND_SLL;
				6'b001000: if (rt_z && rd_z) kind = KIND_JR;
				6'b011000: if (rd_z && sh_z) kind = KIND_MULT;
				6'b011010: if (rd_z && sh_z) kind = KIND_DIV;
				6'b010000: if (rs_z && rt_z && sh_z) kind = KIND_MFHI;
				6'b010010: if (rs_z && rt_z && sh_z) kind = KIND_MFLO;
				default: kind = KIND_UNKNOWN;
			endcase
		end else begin
			case (instr.i.op)
				6'b001111: if (rs_z) kind = KIND_LUI;
				6'b001101: kind = KIND_ORI;
				6'b001000: kind = KIND_ADDI;
				6'b001001: kind = KIND_ADDIU;
				6'b100011: kind = KIND_LW;
				6'b101011: kind = KIND_SW;
				6'b000100: kind = KIND_BEQ;
				6'b000101: kind = KIND_BNE;
				6'b000010: kind = KIND_J;
				6'b000011: kind = KIND_JAL;
				default: kind = KIND_UNKNOWN;
			endcase
		end
	end

	always_comb begin
		case (kind)
			KIND_ADDU, KIND_SUBU, KIND_ADD, KIND_SUB,
			KIND_AND, KIND_OR, KIND_SLT, KIND_SLL: cls = CAL_R;
			KIND_ORI, KIND_ADDI, KIND_ADDIU, KIND_LUI: cls = CAL_I;
			KIND_LW: cls = LOAD;
			KIND_SW: cls = STORE;
			KIND_BEQ, KIND_BNE: cls = BRANCH;
			KIND_J, KIND_JAL: cls = JUMP_I;
			KIND_JR: cls = JUMP_R;
			KIND_MULT, KIND_DIV: cls = CAL_M;
			KIND_MFHI, KIND_MFLO: cls = LOAD_M;
			default: cls = CLS_NOP;
		endcase
	end

	// SLL shifts rt and LUI has no source register
	assign rs_used = (cls inside {CAL_R, CAL_I, LOAD, STORE, BRANCH, JUMP_R, CAL_M})
		&& kind != KIND_SLL && kind != KIND_LUI;
	assign rt_used = cls inside {CAL_R, STORE, BRANCH, CAL_M};

	always_comb begin
		case (cls)
			CAL_R, LOAD_M: dest = instr.r.rd;
			CAL_I, LOAD: dest = instr.i.rt;
			default: dest = (kind == KIND_JAL) ? `REG_RA : `REG_ZERO;
		endcase
	end

endmodule

//--- logic/stage_track.sv
`include "pipe_settings.svh"

module stage_track import ctrl_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic stall,
	input logic flush,
	input op_kind_e d_kind,
	input op_class_e d_cls,
	input logic [`REG_W-1:0] d_rs,
	input logic [`REG_W-1:0] d_rt,
	input logic [`REG_W-1:0] d_dest,
	input exc_code_e d_exc,
	input logic e_alu_overflow,
	input logic m_addr_fault,
	output op_kind_e e_kind,
	output op_class_e e_cls,
	output logic [`REG_W-1:0] e_rs,
	output logic [`REG_W-1:0] e_rt,
	output logic [`REG_W-1:0] e_dest,
	output exc_code_e e_exc,
	output op_kind_e m_kind,
	output op_class_e m_cls,
	output logic [`REG_W-1:0] m_rt,
	output logic [`REG_W-1:0] m_dest,
	output exc_code_e m_exc,
	output op_class_e w_cls,
	output logic [`REG_W-1:0] w_dest
);

	exc_code_e e_exc_next;

	// only the trapping adds raise overflow, an older code is kept as is
	assign e_exc_next = (e_exc == EXC_NONE && e_alu_overflow
		&& e_kind inside {KIND_ADD, KIND_ADDI, KIND_SUB}) ? EXC_OV : e_exc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			e_kind <= KIND_UNKNOWN;
			e_cls <= CLS_NOP;
			e_rs <= `REG_ZERO;
			e_rt <= `REG_ZERO;
			e_dest <= `REG_ZERO;
			e_exc <= EXC_NONE;
		end else if (flush || stall) begin
			e_kind <= KIND_UNKNOWN;
			e_cls <= CLS_NOP;
			e_rs <= `REG_ZERO;
			e_rt <= `REG_ZERO;
			e_dest <= `REG_ZERO;
			e_exc <= EXC_NONE;
		end else begin
			e_kind <= d_kind;
			e_cls <= d_cls;
			e_rs <= d_rs;
			e_rt <= d_rt;
			e_dest <= d_dest;
			e_exc <= d_exc;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			m_kind <= KIND_UNKNOWN;
			m_cls <= CLS_NOP;
			m_rt <= `REG_ZERO;
			m_dest <= `REG_ZERO;
			m_exc <= EXC_NONE;
		end else if (flush) begin
			m_kind <= KIND_UNKNOWN;
			m_cls <= CLS_NOP;
			m_rt <= `REG_ZERO;
			m_dest <= `REG_ZERO;
			m_exc <= EXC_NONE;
		end else begin
			m_kind <= e_kind;
			m_cls <= e_cls;
			m_rt <= e_rt;
			m_dest <= e_dest;
			m_exc <= e_exc_next;
		end
	end

	// a faulting instruction in M is dropped here, never reaching W
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			w_cls <= CLS_NOP;
			w_dest <= `REG_ZERO;
		end else if (flush) begin
			w_cls <= CLS_NOP;
			w_dest <= `REG_ZERO;
		end else begin
			w_cls <= m_cls;
			w_dest <= m_dest;
		end
	end

	a_nop_no_dest: assert property (@(posedge clk) disable iff (!rst_n)
		(e_cls != CLS_NOP || e_dest == `REG_ZERO) && (m_cls != CLS_NOP || m_dest == `REG_ZERO)
		&& (w_cls != CLS_NOP || w_dest == `REG_ZERO));

endmodule

//--- logic/forward_unit.sv
`include "pipe_settings.svh"

module forward_unit import ctrl_pkg::*; (
	input logic [`REG_W-1:0] d_rs,
	input logic [`REG_W-1:0] d_rt,
	input logic [`REG_W-1:0] e_rs,
	input logic [`REG_W-1:0] e_rt,
	input logic [`REG_W-1:0] m_rt,
	input op_class_e m_cls,
	input logic [`REG_W-1:0] m_dest,
	input op_class_e w_cls,
	input logic [`REG_W-1:0] w_dest,
	output fwd_sel_e fwd_d1,
	output fwd_sel_e fwd_d2,
	output fwd_sel_e fwd_e1,
	output fwd_sel_e fwd_e2,
	output fwd_sel_e fwd_m
);

	logic [`REG_W-1:0] m_src;
	logic [`REG_W-1:0] w_src;

	// load data is not there yet in M
	assign m_src = (cls_writes(m_cls) && m_cls != LOAD) ? m_dest : `REG_ZERO;
	assign w_src = cls_writes(w_cls) ? w_dest : `REG_ZERO;

	function automatic fwd_sel_e pick(input logic [`REG_W-1:0] r,
		input logic [`REG_W-1:0] ms, input logic [`REG_W-1:0] ws);
		if (r == `REG_ZERO)
			return FWD_NONE;
		if (r == ms)
			return FWD_M;
		if (r == ws)
			return FWD_W;
		return FWD_NONE;
	endfunction

	assign fwd_d1 = pick(d_rs, m_src, w_src);
	assign fwd_d2 = pick(d_rt, m_src, w_src);
	assign fwd_e1 = pick(e_rs, m_src, w_src);
	assign fwd_e2 = pick(e_rt, m_src, w_src);

	// store data in M can only come from W
	assign fwd_m = pick(m_rt, `REG_ZERO, w_src);

endmodule

//--- logic/hazard_unit.sv
`include "pipe_settings.svh"

module hazard_unit import ctrl_pkg::*; (
	input op_class_e d_cls,
	input op_kind_e d_kind,
	input logic [`REG_W-1:0] d_rs,
	input logic [`REG_W-1:0] d_rt,
	input logic rs_used,
	input logic rt_used,
	input op_class_e e_cls,
	input logic [`REG_W-1:0] e_dest,
	input op_class_e m_cls,
	input logic [`REG_W-1:0] m_dest,
	input logic e_md_busy,
	output logic stall
);

	logic d_early;
	logic d_md;
	logic load_use;
	logic branch_wait;
	logic md_wait;

	function automatic logic reads(input logic [`REG_W-1:0] r,
		input logic [`REG_W-1:0] a, input logic ua, input logic [`REG_W-1:0] b, input logic ub);
		return r != `REG_ZERO && ((ua && a == r) || (ub && b == r));
	endfunction

	// branches and JR compare their operands in D
	assign d_early = d_cls inside {BRANCH, JUMP_R};
	assign d_md = d_kind inside {KIND_MULT, KIND_DIV, KIND_MFHI, KIND_MFLO};

	assign load_use = e_cls == LOAD && reads(e_dest, d_rs, rs_used, d_rt, rt_used);
	assign branch_wait = d_early
		&& ((cls_writes(e_cls) && reads(e_dest, d_rs, rs_used, d_rt, rt_used))
		|| (m_cls == LOAD && reads(m_dest, d_rs, rs_used, d_rt, rt_used)));
	assign md_wait = d_md && (e_md_busy || e_cls == CAL_M);

	assign stall = load_use || branch_wait || md_wait;

endmodule

//--- logic/exc_handler.sv
module exc_handler import ctrl_pkg::*; (
	input op_class_e m_cls,
	input exc_code_e m_exc,
	input logic m_addr_fault,
	output logic exc_valid,
	output exc_code_e exc_code,
	output logic flush
);

	// a code picked up earlier in the pipe beats the address check at M
	always_comb begin
		if (m_exc != EXC_NONE)
			exc_code = m_exc;
		else if (m_addr_fault && m_cls == LOAD)
			exc_code = EXC_ADEL;
		else if (m_addr_fault && m_cls == STORE)
			exc_code = EXC_ADES;
		else
			exc_code = EXC_NONE;
	end

	assign exc_valid = exc_code != EXC_NONE;

	// M and everything younger is thrown away on a report
	assign flush = exc_valid;

endmodule

//--- logic/pipe_control.sv
`include "pipe_settings.svh"

module pipe_control import ctrl_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic [`XLEN-1:0] d_instr,
	input logic e_alu_overflow,
	input logic e_md_busy,
	input logic m_addr_fault,
	output logic pc_enable,
	output logic flush_d,
	output npc_mode_e npc_mode,
	output ext_mode_e ext_mode,
	output logic alu_src,
	output alu_op_e alu_op,
	output md_op_e md_op,
	output logic dm_write,
	output wb_sel_e wb_sel,
	output logic rf_write,
	output logic [`REG_W-1:0] rf_waddr,
	output fwd_sel_e fwd_d1,
	output fwd_sel_e fwd_d2,
	output fwd_sel_e fwd_e1,
	output fwd_sel_e fwd_e2,
	output fwd_sel_e fwd_m,
	output logic exc_valid,
	output exc_code_e exc_code
);

	instr_t d_word;
	op_kind_e d_kind, e_kind, m_kind;
	op_class_e d_cls, e_cls, m_cls, w_cls;
	logic rs_used, rt_used;
	logic [`REG_W-1:0] d_rs, d_rt, d_dest;
	logic [`REG_W-1:0] e_rs, e_rt, e_dest, m_rt, m_dest, w_dest;
	exc_code_e d_exc, e_exc, m_exc;
	logic stall;
	logic flush;

	assign d_word = d_instr;

	instr_kind u_kind (.instr(d_word), .kind(d_kind), .cls(d_cls),
		.rs_used(rs_used), .rt_used(rt_used), .dest(d_dest));

	// unused source fields are zeroed so they never match a producer
	assign d_rs = rs_used ? d_word.r.rs : `REG_ZERO;
	assign d_rt = rt_used ? d_word.r.rt : `REG_ZERO;
	assign d_exc = (d_kind == KIND_UNKNOWN) ? EXC_RI : EXC_NONE;

	stage_track u_track (.clk(clk), .rst_n(rst_n), .stall(stall), .flush(flush),
		.d_kind(d_kind), .d_cls(d_cls), .d_rs(d_rs), .d_rt(d_rt), .d_dest(d_dest),
		.d_exc(d_exc), .e_alu_overflow(e_alu_overflow), .m_addr_fault(m_addr_fault),
		.e_kind(e_kind), .e_cls(e_cls), .e_rs(e_rs), .e_rt(e_rt), .e_dest(e_dest),
		.e_exc(e_exc), .m_kind(m_kind), .m_cls(m_cls), .m_rt(m_rt), .m_dest(m_dest),
		.m_exc(m_exc), .w_cls(w_cls), .w_dest(w_dest));

	forward_unit u_fwd (.d_rs(d_rs), .d_rt(d_rt), .e_rs(e_rs), .e_rt(e_rt), .m_rt(m_rt),
		.m_cls(m_cls), .m_dest(m_dest), .w_cls(w_cls), .w_dest(w_dest), .fwd_d1(fwd_d1),
		.fwd_d2(fwd_d2), .fwd_e1(fwd_e1), .fwd_e2(fwd_e2), .fwd_m(fwd_m));

	hazard_unit u_hazard (.d_cls(d_cls), .d_kind(d_kind), .d_rs(d_rs), .d_rt(d_rt),
		.rs_used(rs_used), .rt_used(rt_used), .e_cls(e_cls), .e_dest(e_dest),
		.m_cls(m_cls), .m_dest(m_dest), .e_md_busy(e_md_busy), .stall(stall));

	exc_handler u_exc (.m_cls(m_cls), .m_exc(m_exc), .m_addr_fault(m_addr_fault),
		.exc_valid(exc_valid), .exc_code(exc_code), .flush(flush));

	assign pc_enable = ~stall;
	assign flush_d = flush;

	always_comb begin
		case (d_kind)
			KIND_BEQ: npc_mode = NPC_EQ;
			KIND_BNE: npc_mode = NPC_NE;
			KIND_J, KIND_JAL: npc_mode = NPC_J;
			KIND_JR: npc_mode = NPC_REG;
			default: npc_mode = NPC_SEQ;
		endcase
	end

	assign ext_mode = (d_kind == KIND_LUI) ? EXT_UPPER : (d_kind == KIND_ORI) ? EXT_ZERO : EXT_SIGN;

	assign alu_src = e_cls inside {CAL_I, LOAD, STORE};

	// LUI goes through OR with a zero rs
	always_comb begin
		case (e_kind)
			KIND_SUBU, KIND_SUB: alu_op = ALU_SUB;
			KIND_AND: alu_op = ALU_AND;
			KIND_OR, KIND_ORI, KIND_LUI: alu_op = ALU_OR;
			KIND_SLT: alu_op = ALU_SLT;
			KIND_SLL: alu_op = ALU_SLL;
			default: alu_op = ALU_ADD;
		endcase
	end

	always_comb begin
		case (e_kind)
			KIND_MULT: md_op = MD_MULT;
			KIND_DIV: md_op = MD_DIV;
			KIND_MFHI: md_op = MD_MFHI;
			KIND_MFLO: md_op = MD_MFLO;
			default: md_op = MD_NONE;
		endcase
	end

	assign dm_write = m_cls == STORE && !exc_valid;

	assign rf_write = cls_writes(w_cls) && w_dest != `REG_ZERO;
	assign rf_waddr = w_dest;

	always_comb begin
		case (w_cls)
			LOAD: wb_sel = WB_MEM;
			JUMP_I, JUMP_R: wb_sel = WB_LINK;
			LOAD_M: wb_sel = WB_MD;
			default: wb_sel = WB_ALU;
		endcase
	end

	// only a reserved word reaches M without a class and still reports
	a_classless_exc: assert property (@(posedge clk) disable iff (!rst_n)
		exc_valid && m_cls == CLS_NOP |-> m_kind == KIND_UNKNOWN && exc_code == EXC_RI);

	// the flush empties M, so a report never lasts two cycles
	a_single_report: assert property (@(posedge clk) disable iff (!rst_n)
		exc_valid |=> !exc_valid);

endmodule

//--- verification/clk_gen.sv
module clk_gen (
	output logic clk,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// reset is released 2 ns after the second rising edge, like every other input
	initial begin
		rst_n = 1'b0;
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;
	end

endmodule

//--- verification/tb_pipe_control.sv
`include "pipe_settings.svh"

module tb_pipe_control import ctrl_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] NOP = 32'h0000_0000;
	localparam logic [31:0] RESERVED = 32'hfc00_0000;
	localparam logic [5:0] F_ADDU = 6'h21;
	localparam logic [5:0] F_SUBU = 6'h23;
	localparam logic [5:0] F_ADD = 6'h20;
	localparam logic [5:0] F_JR = 6'h08;
	localparam logic [5:0] F_MULT = 6'h18;
	localparam logic [5:0] F_MFLO = 6'h12;
	localparam logic [5:0] OP_ORI = 6'h0d;
	localparam logic [5:0] OP_LW = 6'h23;
	localparam logic [5:0] OP_SW = 6'h2b;
	localparam logic [5:0] OP_BEQ = 6'h04;
	localparam logic [5:0] OP_BNE = 6'h05;
	localparam logic [5:0] OP_J = 6'h02;
	localparam logic [5:0] OP_JAL = 6'h03;

	logic clk;
	logic rst_n;
	logic [`XLEN-1:0] d_instr;
	logic e_alu_overflow;
	logic e_md_busy;
	logic m_addr_fault;
	logic pc_enable;
	logic flush_d;
	npc_mode_e npc_mode;
	ext_mode_e ext_mode;
	logic alu_src;
	alu_op_e alu_op;
	md_op_e md_op;
	logic dm_write;
	wb_sel_e wb_sel;
	logic rf_write;
	logic [`REG_W-1:0] rf_waddr;
	fwd_sel_e fwd_d1;
	fwd_sel_e fwd_d2;
	fwd_sel_e fwd_e1;
	fwd_sel_e fwd_e2;
	fwd_sel_e fwd_m;
	logic exc_valid;
	exc_code_e exc_code;

	logic [`REG_W-1:0] r [0:9];

	clk_gen u_clk (.clk(clk), .rst_n(rst_n));

	pipe_control UUT (.*);

	function automatic logic [31:0] r_op(input logic [5:0] funct, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {6'h00, rs, rt, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] i_op(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] j_op(input logic [5:0] op, input logic [25:0] target);
		return {op, target};
	endfunction

	task automatic fail_stop(input string msg);
		$display("%s", msg);
		$display("TB FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
			fail_stop($sformatf("Error in %s: expected %0h, actual %0h", name, exp, act));
	endtask

	task automatic writeback_is(input string name, input logic wr, input logic [4:0] addr,
		input wb_sel_e sel);
		check({name, " rf_write"}, 32'(wr), 32'(rf_write));
		if (wr) begin
			check({name, " rf_waddr"}, 32'(addr), 32'(rf_waddr));
			check({name, " wb_sel"}, 32'(sel), 32'(wb_sel));
		end
	endtask

	task automatic execute_is(input string name, input alu_op_e op, input logic src);
		check({name, " alu_op"}, 32'(op), 32'(alu_op));
		check({name, " alu_src"}, 32'(src), 32'(alu_src));
	endtask

	// inputs change 2 ns after the edge and outputs are read 10 ns later
	task automatic step(input logic [31:0] word, input logic ovf = 1'b0,
		input logic fault = 1'b0, input logic busy = 1'b0);
		@(posedge clk);
		#2;
		d_instr = word;
		e_alu_overflow = ovf;
		m_addr_fault = fault;
		e_md_busy = busy;
		#10;
	endtask

	// a stride coprime to 31 gives ten distinct nonzero registers
	task automatic fresh_regs();
		int start;
		int stride;
		start = $urandom % 31;
		stride = 1 + $urandom % 30;
		for (int i = 0; i < 10; i++)
			r[i] = 5'((start + i * stride) % 31 + 1);
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (rst_n !== 1'b1) begin
			if (n == 10)
				fail_stop("reset was never released");
			@(posedge clk);
			n++;
		end
	endtask

	task automatic reset_state();
		step(NOP);
		check("reset_state pc_enable", 32'(1'b1), 32'(pc_enable));
		check("reset_state rf_write", 32'(1'b0), 32'(rf_write));
		check("reset_state dm_write", 32'(1'b0), 32'(dm_write));
		check("reset_state exc_valid", 32'(1'b0), 32'(exc_valid));
		check("reset_state flush_d", 32'(1'b0), 32'(flush_d));
	endtask

	task automatic stage_words();
		fresh_regs();
		step(r_op(F_ADDU, r[1], r[2], r[3]));
		check("stage_words npc_mode", 32'(NPC_SEQ), 32'(npc_mode));
		step(i_op(OP_ORI, r[4], r[5], 16'h8001));
		check("stage_words ORI ext_mode", 32'(EXT_ZERO), 32'(ext_mode));
		execute_is("stage_words ADDU", ALU_ADD, 1'b0);
		step(i_op(OP_LW, r[6], r[7], 16'h0010));
		check("stage_words LW ext_mode", 32'(EXT_SIGN), 32'(ext_mode));
		execute_is("stage_words ORI", ALU_OR, 1'b1);
		step(i_op(OP_SW, r[8], r[9], 16'h0020));
		execute_is("stage_words LW", ALU_ADD, 1'b1);
		writeback_is("stage_words ADDU", 1'b1, r[1], WB_ALU);
		step(NOP);
		execute_is("stage_words SW", ALU_ADD, 1'b1);
		check("stage_words LW dm_write", 32'(1'b0), 32'(dm_write));
		writeback_is("stage_words ORI", 1'b1, r[4], WB_ALU);
		step(NOP);
		check("stage_words SW dm_write", 32'(1'b1), 32'(dm_write));
		writeback_is("stage_words LW", 1'b1, r[6], WB_MEM);
		step(NOP);
		writeback_is("stage_words SW", 1'b0, 5'd0, WB_ALU);
	endtask

	task automatic forwarding();
		fresh_regs();
		step(r_op(F_ADDU, r[1], r[2], r[3]));
		step(r_op(F_SUBU, r[4], r[1], r[5]));
		step(NOP);
		check("forwarding from M fwd_e1", 32'(FWD_M), 32'(fwd_e1));
		check("forwarding from M fwd_e2", 32'(FWD_NONE), 32'(fwd_e2));
		step(r_op(F_ADDU, r[6], r[2], r[3]));
		step(r_op(F_ADDU, r[7], r[2], r[3]));
		step(r_op(F_SUBU, r[4], r[6], r[5]));
		step(NOP);
		check("forwarding from W fwd_e1", 32'(FWD_W), 32'(fwd_e1));
		step(r_op(F_ADDU, 5'd0, r[2], r[3]));
		step(r_op(F_SUBU, r[4], 5'd0, r[5]));
		step(NOP);
		check("forwarding zero fwd_e1", 32'(FWD_NONE), 32'(fwd_e1));
		step(r_op(F_ADDU, r[8], r[2], r[3]));
		step(i_op(OP_SW, r[8], r[9], 16'h0004));
		step(NOP);
		step(NOP);
		check("forwarding store data fwd_m", 32'(FWD_W), 32'(fwd_m));
	endtask

	task automatic load_use();
		fresh_regs();
		step(i_op(OP_LW, r[1], r[2], 16'h0000));
		step(r_op(F_ADDU, r[3], r[1], r[4]));
		check("load_use stall", 32'(1'b0), 32'(pc_enable));
		step(r_op(F_ADDU, r[3], r[1], r[4]));
		check("load_use release", 32'(1'b1), 32'(pc_enable));
		step(NOP);
		writeback_is("load_use LW", 1'b1, r[1], WB_MEM);
		check("load_use fwd_e1", 32'(FWD_W), 32'(fwd_e1));
		step(NOP);
		writeback_is("load_use bubble", 1'b0, 5'd0, WB_ALU);
		step(NOP);
		writeback_is("load_use ADDU", 1'b1, r[3], WB_ALU);
		// a branch waits one cycle on an ALU result and two on a load
		step(r_op(F_ADDU, r[5], r[2], r[4]));
		step(i_op(OP_BEQ, r[6], r[5], 16'h0003));
		check("load_use branch after ALU stall", 32'(1'b0), 32'(pc_enable));
		step(i_op(OP_BEQ, r[6], r[5], 16'h0003));
		check("load_use branch after ALU release", 32'(1'b1), 32'(pc_enable));
		check("load_use branch fwd_d1", 32'(FWD_M), 32'(fwd_d1));
		step(i_op(OP_LW, r[7], r[2], 16'h0008));
		step(i_op(OP_BNE, r[7], r[8], 16'h0003));
		check("load_use branch after LW stall 1", 32'(1'b0), 32'(pc_enable));
		step(i_op(OP_BNE, r[7], r[8], 16'h0003));
		check("load_use branch after LW stall 2", 32'(1'b0), 32'(pc_enable));
		step(i_op(OP_BNE, r[7], r[8], 16'h0003));
		check("load_use branch after LW release", 32'(1'b1), 32'(pc_enable));
		check("load_use branch fwd_d2", 32'(FWD_W), 32'(fwd_d2));
		repeat (3) step(NOP);
	endtask

	task automatic next_pc();
		fresh_regs();
		step(i_op(OP_BEQ, r[2], r[1], 16'h0004));
		check("next_pc BEQ", 32'(NPC_EQ), 32'(npc_mode));
		step(i_op(OP_BNE, r[4], r[3], 16'h0004));
		check("next_pc BNE", 32'(NPC_NE), 32'(npc_mode));
		step(j_op(OP_J, 26'h000_0040));
		check("next_pc J", 32'(NPC_J), 32'(npc_mode));
		step(r_op(F_JR, 5'd0, r[5], 5'd0));
		check("next_pc JR", 32'(NPC_REG), 32'(npc_mode));
		step(j_op(OP_JAL, 26'h000_0080));
		check("next_pc JAL", 32'(NPC_J), 32'(npc_mode));
		step(NOP);
		check("next_pc NOP", 32'(NPC_SEQ), 32'(npc_mode));
		step(NOP);
		step(NOP);
		writeback_is("next_pc JAL link", 1'b1, `REG_RA, WB_LINK);
	endtask

	// the faulting word and the two younger ones must all vanish
	task automatic trap_case(input string name, input logic [31:0] word, input logic ovf,
		input logic fault, input exc_code_e code);
		step(word);
		step(r_op(F_ADDU, r[1], r[2], r[3]), ovf);
		step(i_op(OP_ORI, r[4], r[5], 16'h0001), 1'b0, fault);
		check({name, " exc_valid"}, 32'(1'b1), 32'(exc_valid));
		check({name, " exc_code"}, 32'(code), 32'(exc_code));
		check({name, " flush_d"}, 32'(1'b1), 32'(flush_d));
		check({name, " dm_write"}, 32'(1'b0), 32'(dm_write));
		repeat (3) begin
			step(NOP);
			check({name, " rf_write after flush"}, 32'(1'b0), 32'(rf_write));
			check({name, " exc_valid after flush"}, 32'(1'b0), 32'(exc_valid));
		end
	endtask

	task automatic exceptions();
		fresh_regs();
		trap_case("exceptions RI", RESERVED, 1'b0, 1'b0, EXC_RI);
		trap_case("exceptions OV", r_op(F_ADD, r[6], r[2], r[3]), 1'b1, 1'b0, EXC_OV);
		trap_case("exceptions ADES", i_op(OP_SW, r[8], r[9], 16'h0002), 1'b0, 1'b1, EXC_ADES);
		trap_case("exceptions ADEL", i_op(OP_LW, r[7], r[9], 16'h0001), 1'b0, 1'b1, EXC_ADEL);
		// ADDU ignores overflow and still writes back
		step(r_op(F_ADDU, r[6], r[2], r[3]));
		step(NOP, 1'b1);
		step(NOP);
		check("exceptions ADDU no trap", 32'(1'b0), 32'(exc_valid));
		step(NOP);
		writeback_is("exceptions ADDU", 1'b1, r[6], WB_ALU);
	endtask

	task automatic md_busy();
		logic [31:0] mflo;
		int n;
		fresh_regs();
		mflo = r_op(F_MFLO, r[3], 5'd0, 5'd0);
		step(r_op(F_MULT, 5'd0, r[1], r[2]));
		check("md_busy MULT issue", 32'(1'b1), 32'(pc_enable));
		step(mflo);
		check("md_busy MULT in E stall", 32'(1'b0), 32'(pc_enable));
		check("md_busy MULT md_op", 32'(MD_MULT), 32'(md_op));
		step(mflo, 1'b0, 1'b0, 1'b1);
		n = 0;
		while (!pc_enable) begin
			if (n == 20)
				fail_stop("MFLO was still stalled long after e_md_busy fell");
			n++;
			step(mflo, 1'b0, 1'b0, n < 3);
		end
		check("md_busy release cycle", 32'(3), 32'(n));
		step(NOP);
		check("md_busy MFLO md_op", 32'(MD_MFLO), 32'(md_op));
		step(NOP);
		step(NOP);
		writeback_is("md_busy MFLO", 1'b1, r[3], WB_MD);
	endtask

	initial begin
		d_instr = NOP;
		e_alu_overflow = 1'b0;
		e_md_busy = 1'b0;
		m_addr_fault = 1'b0;
		void'($urandom(32'h7a33));
		wait_reset();
		reset_state();
		stage_words();
		forwarding();
		load_use();
		next_pc();
		exceptions();
		md_busy();
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- tb.f
+incdir+logic
logic/ctrl_pkg.sv
logic/instr_kind.sv
logic/stage_track.sv
logic/forward_unit.sv
logic/hazard_unit.sv
logic/exc_handler.sv
logic/pipe_control.sv
verification/clk_gen.sv
verification/tb_pipe_control.sv

//--- Makefile
TOP = tb_pipe_control

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f tb.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
